// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    // datapath width
    localparam int xlen = 32;

    // architectural register index
    localparam int reg_idx_w = 5;

    // number of architectural registers
    localparam int num_regs = 32;

    // micro-op code width
    localparam int uop_w = 3;

    // hardwired zero register
    localparam logic [reg_idx_w-1:0] reg_zero = '0;

    // pc placed on a bubble slot
    localparam logic [xlen-1:0] nop_pc = '0;

    // decoded micro-op classes seen by the issue stage
    // nop must stay at zero so a cleared slot decodes as a bubble
    typedef enum logic [uop_w-1:0] {
        // empty slot
        uop_nop    = 3'd0,
        // integer alu op
        uop_alu    = 3'd1,
        // memory read, lane 0 only
        uop_load   = 3'd2,
        // memory write
        uop_store  = 3'd3,
        // branch or jump
        uop_branch = 3'd4
    } uop_e;

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 aresetn,
    // writeback lane 0
    input  logic                 we0,
    input  logic [reg_idx_w-1:0] waddr0,
    input  logic [xlen-1:0]      wdata0,
    // writeback lane 1
    input  logic                 we1,
    input  logic [reg_idx_w-1:0] waddr1,
    input  logic [xlen-1:0]      wdata1,
    // four source read ports
    input  logic [reg_idx_w-1:0] raddr0,
    input  logic [reg_idx_w-1:0] raddr1,
    input  logic [reg_idx_w-1:0] raddr2,
    input  logic [reg_idx_w-1:0] raddr3,
    output logic [xlen-1:0]      rdata0,
    output logic [xlen-1:0]      rdata1,
    output logic [xlen-1:0]      rdata2,
    output logic [xlen-1:0]      rdata3
);

    // architectural state
    logic [xlen-1:0] regs [num_regs];

    // one read port with write-first bypass
    // lane 1 checked last so it wins on a double hit
    function automatic logic [xlen-1:0] read_port(input logic [reg_idx_w-1:0] raddr);
        logic [xlen-1:0] data;
        data = regs[raddr];
        if (we0 && (waddr0 == raddr)) begin
            data = wdata0;
        end
        if (we1 && (waddr1 == raddr)) begin
            data = wdata1;
        end
        // r0 is constant zero, bypass included
        if (raddr == reg_zero) begin
            data = '0;
        end
        return data;
    endfunction

    // writes land on the rising edge
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // lane 1 after lane 0, same target keeps lane 1
            if (we0 && (waddr0 != reg_zero)) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && (waddr1 != reg_zero)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // combinational reads, same-cycle data
    always_comb begin
        rdata0 = read_port(raddr0);
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
        rdata3 = read_port(raddr3);
    end

endmodule

// ==== verilog/load_use_detect.sv ====
`timescale 1ns/1ps

module load_use_detect import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 aresetn,
    // sources of the incoming pair
    input  logic [reg_idx_w-1:0] rj0,
    input  logic [reg_idx_w-1:0] rk0,
    input  logic [reg_idx_w-1:0] rj1,
    input  logic [reg_idx_w-1:0] rk1,
    // lane 0 of the execute register
    input  uop_e                 ex_uop0,
    input  logic [reg_idx_w-1:0] ex_rd0,
    // execute slot handed on this edge
    input  logic                 consume,
    output logic                 stall
);

    // load in execute right now
    logic                 ex_is_load;
    logic [reg_idx_w-1:0] ex_load_rd;

    // older load destinations, entry 0 is the most recent
    // covers the extra dcache pipeline cycles after execute
    logic [reg_idx_w-1:0] hist0;
    logic [reg_idx_w-1:0] hist1;

    // per-destination match flags
    logic hit_ex;
    logic hit_h0;
    logic hit_h1;

    // true when any incoming source reads dst
    // zero dst means no pending load
    function automatic logic src_hit(input logic [reg_idx_w-1:0] dst);
        logic any_src;
        any_src = (rj0 == dst) || (rk0 == dst) || (rj1 == dst) || (rk1 == dst);
        return (dst != reg_zero) && any_src;
    endfunction

    assign ex_is_load = (ex_uop0 == uop_load);
    // non-loads push zero so they never match
    assign ex_load_rd = ex_is_load ? ex_rd0 : reg_zero;

    // history moves only when execute hands its slot on
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            hist0 <= reg_zero;
            hist1 <= reg_zero;
        end else if (consume) begin
            hist1 <= hist0;
            hist0 <= ex_load_rd;
        end
    end

    // same-cycle stall decision
    always_comb begin
        hit_ex = src_hit(ex_load_rd);
        hit_h0 = src_hit(hist0);
        hit_h1 = src_hit(hist1);
        stall  = hit_ex || hit_h0 || hit_h1;
    end

endmodule

// ==== verilog/reg_ex_stage.sv ====
`timescale 1ns/1ps

module reg_ex_stage import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 flush,
    // handshake
    input  logic                 id_readygo,
    input  logic                 ex_allowin,
    input  logic                 stall,
    // decoded pair
    input  logic [xlen-1:0]      pc0,
    input  logic [xlen-1:0]      pc1,
    input  logic [xlen-1:0]      imm0,
    input  logic [xlen-1:0]      imm1,
    input  uop_e                 uop0,
    input  uop_e                 uop1,
    input  logic [reg_idx_w-1:0] rj0,
    input  logic [reg_idx_w-1:0] rk0,
    input  logic [reg_idx_w-1:0] rd0,
    input  logic [reg_idx_w-1:0] rj1,
    input  logic [reg_idx_w-1:0] rk1,
    input  logic [reg_idx_w-1:0] rd1,
    // regfile read data
    input  logic [xlen-1:0]      rj0_data,
    input  logic [xlen-1:0]      rk0_data,
    input  logic [xlen-1:0]      rj1_data,
    input  logic [xlen-1:0]      rk1_data,
    output logic                 reg_allowin,
    output logic                 ex_readygo,
    output logic                 consume,
    // execute pipeline register
    output logic [xlen-1:0]      ex_pc0,
    output logic [xlen-1:0]      ex_pc1,
    output logic [xlen-1:0]      ex_imm0,
    output logic [xlen-1:0]      ex_imm1,
    output uop_e                 ex_uop0,
    output uop_e                 ex_uop1,
    output logic [reg_idx_w-1:0] ex_rd0,
    output logic [reg_idx_w-1:0] ex_rd1,
    output logic [xlen-1:0]      ex_rj0_data,
    output logic [xlen-1:0]      ex_rk0_data,
    output logic [xlen-1:0]      ex_rj1_data,
    output logic [xlen-1:0]      ex_rk1_data
);

    // pair accepted on this edge
    logic accept;
    // accepted and not killed by flush
    logic take;

    // operand capture, r0 sources forced to constant zero
    function automatic logic [xlen-1:0] operand(
        input logic [reg_idx_w-1:0] idx,
        input logic [xlen-1:0]      data
    );
        return (idx == reg_zero) ? '0 : data;
    endfunction

    // upstream may move only if execute takes and no load-use hazard
    assign reg_allowin = ex_allowin && !stall;
    assign accept      = id_readygo && reg_allowin;
    // flush beats a same-edge accept
    assign take        = accept && !flush;
    // execute hands its slot on
    assign consume     = ex_readygo && ex_allowin;

    // load on take, bubble on flush or empty slot
    // everything holds while execute is back-pressured
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_readygo  <= 1'b0;
            ex_pc0      <= nop_pc;
            ex_pc1      <= nop_pc;
            ex_imm0     <= '0;
            ex_imm1     <= '0;
            ex_uop0     <= uop_nop;
            ex_uop1     <= uop_nop;
            ex_rd0      <= reg_zero;
            ex_rd1      <= reg_zero;
            ex_rj0_data <= '0;
            ex_rk0_data <= '0;
            ex_rj1_data <= '0;
            ex_rk1_data <= '0;
        end else if (ex_allowin) begin
            ex_readygo  <= take;
            ex_pc0      <= take ? pc0 : nop_pc;
            ex_pc1      <= take ? pc1 : nop_pc;
            ex_imm0     <= take ? imm0 : '0;
            ex_imm1     <= take ? imm1 : '0;
            ex_uop0     <= take ? uop0 : uop_nop;
            ex_uop1     <= take ? uop1 : uop_nop;
            ex_rd0      <= take ? rd0 : reg_zero;
            ex_rd1      <= take ? rd1 : reg_zero;
            // lane 0 operands
            ex_rj0_data <= take ? operand(rj0, rj0_data) : '0;
            ex_rk0_data <= take ? operand(rk0, rk0_data) : '0;
            // lane 1 operands
            ex_rj1_data <= take ? operand(rj1, rj1_data) : '0;
            ex_rk1_data <= take ? operand(rk1, rk1_data) : '0;
        end
    end

endmodule

// ==== verilog/issue_read_top.sv ====
`timescale 1ns/1ps

module issue_read_top import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 flush,
    // decode side
    input  logic                 id_readygo,
    input  logic [xlen-1:0]      pc0,
    input  logic [xlen-1:0]      pc1,
    input  uop_e                 uop0,
    input  uop_e                 uop1,
    input  logic [reg_idx_w-1:0] rj0,
    input  logic [reg_idx_w-1:0] rk0,
    input  logic [reg_idx_w-1:0] rd0,
    input  logic [reg_idx_w-1:0] rj1,
    input  logic [reg_idx_w-1:0] rk1,
    input  logic [reg_idx_w-1:0] rd1,
    input  logic [xlen-1:0]      imm0,
    input  logic [xlen-1:0]      imm1,
    output logic                 reg_allowin,
    // writeback side
    input  logic                 we0,
    input  logic [reg_idx_w-1:0] waddr0,
    input  logic [xlen-1:0]      wdata0,
    input  logic                 we1,
    input  logic [reg_idx_w-1:0] waddr1,
    input  logic [xlen-1:0]      wdata1,
    // execute side
    input  logic                 ex_allowin,
    output logic                 ex_readygo,
    output logic [xlen-1:0]      ex_pc0,
    output logic [xlen-1:0]      ex_pc1,
    output uop_e                 ex_uop0,
    output uop_e                 ex_uop1,
    output logic [reg_idx_w-1:0] ex_rd0,
    output logic [reg_idx_w-1:0] ex_rd1,
    output logic [xlen-1:0]      ex_imm0,
    output logic [xlen-1:0]      ex_imm1,
    output logic [xlen-1:0]      ex_rj0_data,
    output logic [xlen-1:0]      ex_rk0_data,
    output logic [xlen-1:0]      ex_rj1_data,
    output logic [xlen-1:0]      ex_rk1_data
);

    // read data into the pipeline register
    logic [xlen-1:0] rj0_data;
    logic [xlen-1:0] rk0_data;
    logic [xlen-1:0] rj1_data;
    logic [xlen-1:0] rk1_data;
    // hazard and history strobes
    logic            stall;
    logic            consume;

    // port order rj0, rk0, rj1, rk1
    regfile regfile_i (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (we0),
        .waddr0  (waddr0),
        .wdata0  (wdata0),
        .we1     (we1),
        .waddr1  (waddr1),
        .wdata1  (wdata1),
        .raddr0  (rj0),
        .raddr1  (rk0),
        .raddr2  (rj1),
        .raddr3  (rk1),
        .rdata0  (rj0_data),
        .rdata1  (rk0_data),
        .rdata2  (rj1_data),
        .rdata3  (rk1_data)
    );

    // watches the execute lane 0 load and older loads
    load_use_detect load_use_detect_i (
        .clk     (clk),
        .aresetn (aresetn),
        .rj0     (rj0),
        .rk0     (rk0),
        .rj1     (rj1),
        .rk1     (rk1),
        .ex_uop0 (ex_uop0),
        .ex_rd0  (ex_rd0),
        .consume (consume),
        .stall   (stall)
    );

    reg_ex_stage reg_ex_stage_i (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .id_readygo  (id_readygo),
        .ex_allowin  (ex_allowin),
        .stall       (stall),
        .pc0         (pc0),
        .pc1         (pc1),
        .imm0        (imm0),
        .imm1        (imm1),
        .uop0        (uop0),
        .uop1        (uop1),
        .rj0         (rj0),
        .rk0         (rk0),
        .rd0         (rd0),
        .rj1         (rj1),
        .rk1         (rk1),
        .rd1         (rd1),
        .rj0_data    (rj0_data),
        .rk0_data    (rk0_data),
        .rj1_data    (rj1_data),
        .rk1_data    (rk1_data),
        .reg_allowin (reg_allowin),
        .ex_readygo  (ex_readygo),
        .consume     (consume),
        .ex_pc0      (ex_pc0),
        .ex_pc1      (ex_pc1),
        .ex_imm0     (ex_imm0),
        .ex_imm1     (ex_imm1),
        .ex_uop0     (ex_uop0),
        .ex_uop1     (ex_uop1),
        .ex_rd0      (ex_rd0),
        .ex_rd1      (ex_rd1),
        .ex_rj0_data (ex_rj0_data),
        .ex_rk0_data (ex_rk0_data),
        .ex_rj1_data (ex_rj1_data),
        .ex_rk1_data (ex_rk1_data)
    );

endmodule

// ==== dv/issue_read_tb.sv ====
`timescale 1ns/1ps

module issue_read_tb import issue_pkg::*; ();

    // dut inputs
    logic                 clk;
    logic                 aresetn;
    logic                 flush;
    logic                 id_readygo;
    logic                 ex_allowin;
    logic                 we0;
    logic                 we1;
    logic [reg_idx_w-1:0] waddr0;
    logic [reg_idx_w-1:0] waddr1;
    logic [xlen-1:0]      wdata0;
    logic [xlen-1:0]      wdata1;
    logic [xlen-1:0]      pc0;
    logic [xlen-1:0]      pc1;
    logic [xlen-1:0]      imm0;
    logic [xlen-1:0]      imm1;
    uop_e                 uop0;
    uop_e                 uop1;
    logic [reg_idx_w-1:0] rj0;
    logic [reg_idx_w-1:0] rk0;
    logic [reg_idx_w-1:0] rd0;
    logic [reg_idx_w-1:0] rj1;
    logic [reg_idx_w-1:0] rk1;
    logic [reg_idx_w-1:0] rd1;
    // dut outputs
    logic                 reg_allowin;
    logic                 ex_readygo;
    logic [xlen-1:0]      ex_pc0;
    logic [xlen-1:0]      ex_pc1;
    logic [xlen-1:0]      ex_imm0;
    logic [xlen-1:0]      ex_imm1;
    uop_e                 ex_uop0;
    uop_e                 ex_uop1;
    logic [reg_idx_w-1:0] ex_rd0;
    logic [reg_idx_w-1:0] ex_rd1;
    logic [xlen-1:0]      ex_rj0_data;
    logic [xlen-1:0]      ex_rk0_data;
    logic [xlen-1:0]      ex_rj1_data;
    logic [xlen-1:0]      ex_rk1_data;
    // raw uop codes from the vector, cast onto the enum inputs
    logic [uop_w-1:0]     vec_uop0;
    logic [uop_w-1:0]     vec_uop1;
    // expected values of the current cycle
    logic                 exp_allowin;
    logic                 exp_readygo;
    logic [uop_w-1:0]     exp_uop0;
    logic [reg_idx_w-1:0] exp_rd0;
    logic [xlen-1:0]      exp_rj0;
    logic [xlen-1:0]      exp_rk0;
    logic [xlen-1:0]      exp_rj1;
    logic [xlen-1:0]      exp_rk1;
    // side fields of the pair last taken into execute
    logic [xlen-1:0]      held_pc0;
    logic [xlen-1:0]      held_pc1;
    logic [xlen-1:0]      held_imm0;
    logic [xlen-1:0]      held_imm1;
    logic [uop_w-1:0]     held_uop1;
    logic [reg_idx_w-1:0] held_rd1;
    // data lines of the vector file
    string                vectors[$];
    bit                   vectors_loaded;
    int                   error_count;
    int                   check_count;

    issue_read_top dut_i (.*);

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %t %s got %h expected %h", $realtime, name, got, exp);
        end
    endtask

    // comment and blank lines are dropped
    task automatic load_vectors(output bit ok);
        int    fd;
        string line;
        ok = 1'b0;
        fd = $fopen("dv/issue_read_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/issue_read_tests.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                vectors.push_back(line);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("the vector file holds no vectors");
            error_count++;
        end else begin
            ok = 1'b1;
            vectors_loaded = 1'b1;
        end
    endtask

    // drives the stimulus and latches the expected columns
    task automatic apply_vector(input int idx, output bit ok);
        int n;
        n = $sscanf(vectors[idx], "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    flush, id_readygo, ex_allowin,
                    we0, waddr0, wdata0, we1, waddr1, wdata1,
                    pc0, pc1, vec_uop0, vec_uop1,
                    rj0, rk0, rd0, rj1, rk1, rd1, imm0, imm1,
                    exp_allowin, exp_readygo, exp_uop0, exp_rd0,
                    exp_rj0, exp_rk0, exp_rj1, exp_rk1);
        uop0 = uop_e'(vec_uop0);
        uop1 = uop_e'(vec_uop1);
        ok = (n == 29);
        if (!ok) begin
            $display("vector %0d could not be parsed, %0d fields read", idx, n);
            error_count++;
        end
    endtask

    // a pair enters execute on the coming edge when accepted and not flushed
    task automatic track_taken_pair();
        if (ex_allowin && id_readygo && exp_allowin && !flush) begin
            held_pc0  = pc0;
            held_pc1  = pc1;
            held_imm0 = imm0;
            held_imm1 = imm1;
            held_uop1 = vec_uop1;
            held_rd1  = rd1;
        end
    endtask

    task automatic compare_outputs();
        check_value("reg_allowin", 32'(reg_allowin), 32'(exp_allowin));
        check_value("ex_readygo", 32'(ex_readygo), 32'(exp_readygo));
        check_value("ex_uop0", 32'(ex_uop0), 32'(exp_uop0));
        check_value("ex_rd0", 32'(ex_rd0), 32'(exp_rd0));
        check_value("ex_rj0_data", ex_rj0_data, exp_rj0);
        check_value("ex_rk0_data", ex_rk0_data, exp_rk0);
        check_value("ex_rj1_data", ex_rj1_data, exp_rj1);
        check_value("ex_rk1_data", ex_rk1_data, exp_rk1);
        // side fields follow the last taken pair, all zero on a bubble
        check_value("ex_pc0", ex_pc0, exp_readygo ? held_pc0 : 32'h0);
        check_value("ex_pc1", ex_pc1, exp_readygo ? held_pc1 : 32'h0);
        check_value("ex_imm0", ex_imm0, exp_readygo ? held_imm0 : 32'h0);
        check_value("ex_imm1", ex_imm1, exp_readygo ? held_imm1 : 32'h0);
        check_value("ex_uop1", 32'(ex_uop1), exp_readygo ? 32'(held_uop1) : 32'h0);
        check_value("ex_rd1", 32'(ex_rd1), exp_readygo ? 32'(held_rd1) : 32'h0);
    endtask

    initial begin
        bit ok;
        bit parsed;
        $timeformat(-9, 1, " ns", 0);
        error_count    = 0;
        check_count    = 0;
        vectors_loaded = 1'b0;
        held_pc0       = '0;
        held_pc1       = '0;
        held_imm0      = '0;
        held_imm1      = '0;
        held_uop1      = '0;
        held_rd1       = '0;
        // quiet inputs, reset held
        aresetn    = 1'b0;
        flush      = 1'b0;
        id_readygo = 1'b0;
        ex_allowin = 1'b0;
        we0        = 1'b0;
        we1        = 1'b0;
        waddr0     = '0;
        waddr1     = '0;
        wdata0     = '0;
        wdata1     = '0;
        pc0        = '0;
        pc1        = '0;
        imm0       = '0;
        imm1       = '0;
        uop0       = uop_nop;
        uop1       = uop_nop;
        rj0        = '0;
        rk0        = '0;
        rd0        = '0;
        rj1        = '0;
        rk1        = '0;
        rd1        = '0;
        load_vectors(ok);
        if (!ok) begin
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #1;
            aresetn = 1'b1;
            // drive 1 ns after the edge, sample 1 ns before the next
            for (int i = 0; i < vectors.size(); i++) begin
                apply_vector(i, parsed);
                #2;
                if (parsed) begin
                    compare_outputs();
                    track_taken_pair();
                end
                @(posedge clk);
                #1;
            end
            $display("run ended: %0d checks, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // budget of vector count plus 20 clock periods
    initial begin
        wait (vectors_loaded);
        #((vectors.size() + 20) * 4);
        $display("timeout: the vectors did not complete in the allowed time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== dv/issue_read_tests.txt ====
# stim: flush id_readygo ex_allowin we0 waddr0 wdata0 we1 waddr1 wdata1 pc0 pc1 uop0 uop1
#       rj0 rk0 rd0 rj1 rk1 rd1 imm0 imm1, then expect: reg_allowin ex_readygo ex_uop0 ex_rd0
#       ex_rj0_data ex_rk0_data ex_rj1_data ex_rk1_data, all hex, seen just before the next edge
# reset state, write then read, bypass, dual write to r7, r0 write
0 0 1  1 1 11 1 2 22  0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0
0 1 1  1 3 33 1 4 44  100 104 1 1 1 2 5 3 4 6 1 2  1 0 0 0 0 0 0 0
0 1 1  1 7 aa 1 7 bb  108 10c 1 1 7 0 8 7 1 9 3 4  1 1 1 5 11 22 33 44
0 1 1  1 0 ff 1 9 99  110 114 1 1 7 0 a 9 2 b 5 6  1 1 1 8 bb 0 bb 11
0 1 1  0 0 0 0 0 0  118 11c 1 1 0 9 c 3 4 d 7 8  1 1 1 a bb 0 99 22
# lane 0 load to r5, dependent pair stalls on execute then on history
0 1 1  0 0 0 0 0 0  120 124 2 1 1 0 5 2 3 6 9 a  1 1 1 c 0 99 33 44
0 1 1  0 0 0 0 0 0  128 12c 1 1 5 1 7 2 3 8 b c  0 1 2 5 11 0 22 33
0 1 1  0 0 0 0 0 0  128 12c 1 1 5 1 7 2 3 8 b c  0 0 0 0 0 0 0 0
# two independent issues, r5 two back still stalls, three back does not
0 1 1  1 5 55 0 0 0  130 134 1 1 1 2 e 3 4 f d e  1 0 0 0 0 0 0 0
0 1 1  0 0 0 0 0 0  138 13c 1 1 2 3 10 4 1 11 f 10  1 1 1 e 11 22 33 44
0 1 1  0 0 0 0 0 0  140 144 1 1 1 2 13 3 5 12 11 12  0 1 1 10 22 33 44 11
0 1 1  0 0 0 0 0 0  140 144 1 1 1 2 13 3 5 12 11 12  1 0 0 0 0 0 0 0
# load to r0 never stalls
0 1 1  0 0 0 0 0 0  148 14c 2 1 1 0 0 2 3 14 13 14  1 1 1 13 11 22 33 55
0 1 1  0 0 0 0 0 0  150 154 1 1 0 0 15 0 1 16 15 16  1 1 2 0 11 0 22 33
# back-pressure holds, flush waits for ex_allowin
0 1 0  0 0 0 0 0 0  158 15c 1 1 1 2 17 3 4 18 17 18  0 1 1 15 0 0 0 11
1 1 0  0 0 0 0 0 0  158 15c 1 1 1 2 17 3 4 18 17 18  0 1 1 15 0 0 0 11
1 1 1  0 0 0 0 0 0  158 15c 1 1 1 2 17 3 4 18 17 18  1 1 1 15 0 0 0 11
0 1 1  0 0 0 0 0 0  158 15c 1 1 1 2 17 3 4 18 17 18  1 0 0 0 0 0 0 0
0 0 0  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  0 1 1 17 11 22 33 44
0 0 1  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  1 1 1 17 11 22 33 44
0 0 1  0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0

// ==== sim.f ====
verilog/issue_pkg.sv
verilog/regfile.sv
verilog/load_use_detect.sv
verilog/reg_ex_stage.sv
verilog/issue_read_top.sv
dv/issue_read_tb.sv

// ==== Makefile ====
TOP := issue_read_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -o sim_bin

run: build
	@out="$$(./obj_dir/sim_bin)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --top-module issue_read_top \
		verilog/issue_pkg.sv verilog/regfile.sv verilog/load_use_detect.sv \
		verilog/reg_ex_stage.sv verilog/issue_read_top.sv

clean:
	rm -rf obj_dir
